/* Bender.yml */
package:
  name: dcache

sources:
  - include_dirs:
      - .
    files:
      - dcache_pkg.sv
      - cache_line.sv
      - line_select.sv
      - load_store_align.sv
      - backing_memory.sv
      - dcache_ctrl.sv
      - dcache_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - dcache_tb.sv

/* backing_memory.sv */
// Line-wide backing RAM without reset; contents are undefined until written, reads see old data on collision
`timescale 1ns/1ps
`default_nettype none

`include "dcache_config.svh"

module backing_memory
	import dcache_pkg::*;
(
	input  wire        clk,
	input  wire        we,
	input  mem_index_t widx,
	input  line_data_t wline,
	input  mem_index_t ridx,
	output line_data_t rline
);

	line_data_t mem [`DCACHE_MEM_LINES];

	// Write-back port for victims
	always_ff @(posedge clk) begin
		if (we) begin
			mem[widx] <= wline;
		end
	end

	// Fill port with one cycle of latency
	always_ff @(posedge clk) begin
		rline <= mem[ridx];
	end

endmodule

`default_nettype wire

/* cache_line.sv */
// One cache way; init_age must be unique per way and below DCACHE_LINES so the ages form a permutation
`timescale 1ns/1ps
`default_nettype none

`include "dcache_config.svh"

module cache_line
	import dcache_pkg::*;
#(
	parameter int unsigned init_age = 0
) (
	input  wire        clk,
	input  wire        arst_n,
	input  addr_t      cur_addr,
	input  wire        select,
	input  age_t       acc_age,
	input  wire        touch,
	input  wire        write,
	input  line_data_t wline,
	output way_state_t state,
	output line_data_t data
);

	logic       valid_q;
	age_t       age_q;
	tag_t       tag_q;
	line_data_t data_q;

	// Control state of the way
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			valid_q <= 1'b0;
			age_q   <= age_t'(init_age);
		end else begin
			if (write && select) begin
				valid_q <= 1'b1;
			end
			// The accessed way becomes the newest, younger ways than its old age step down
			if (touch) begin
				if (select) begin
					age_q <= age_t'(`DCACHE_LINES - 1);
				end else if (age_q > acc_age) begin
					age_q <= age_q - 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (write && select) begin
			tag_q  <= cur_addr[`DCACHE_ADDR_BITS-1:`DCACHE_OFFSET_BITS];
			data_q <= wline;
		end
	end

	assign state.valid = valid_q;
	assign state.tag   = tag_q;
	assign state.age   = age_q;
	assign data        = data_q;

endmodule

`default_nettype wire

/* dcache.f */
+incdir+.
dcache_pkg.sv
cache_line.sv
line_select.sv
load_store_align.sv
backing_memory.sv
dcache_ctrl.sv
dcache_top.sv
dcache_tb.sv

/* dcache_config.svh */
// Geometry is fixed at 4 ways of 8-byte lines over 4 KiB of data space; other values are untested
`ifndef DCACHE_CONFIG_SVH
`define DCACHE_CONFIG_SVH

// Byte address width of the processor memory port
`define DCACHE_ADDR_BITS 14

// Line geometry
`define DCACHE_LINE_BYTES 8
`define DCACHE_LINE_WORDS 2
`define DCACHE_OFFSET_BITS 3

// Number of ways and the width of the recency counter that orders them
`define DCACHE_LINES 4
`define DCACHE_AGE_BITS 2

// Backing memory depth in lines (4 KiB)
`define DCACHE_MEM_LINES 512

// First byte address that maps onto backing memory line 0
`define DCACHE_DATA_BASE 14'h1000

// Memory-mapped LED register, never cached
`define DCACHE_LED_ADDR 14'h2000

`endif

/* dcache_ctrl.sv */
// Cache controller; only one miss in flight and addresses below DCACHE_DATA_BASE wrap into the memory
`timescale 1ns/1ps
`default_nettype none

`include "dcache_config.svh"

module dcache_ctrl
	import dcache_pkg::*;
(
	input  wire        clk,
	input  wire        arst_n,
	input  mem_req_t   req,
	output mem_req_t   cur_req,
	input  wire        hit,
	input  way_state_t sel_state,
	input  line_data_t sel_data,
	input  word_t      load_word,
	output logic       way_write,
	output logic       way_touch,
	output logic       mem_we,
	output mem_index_t mem_widx,
	output line_data_t mem_wline,
	output mem_index_t mem_ridx,
	output word_t      read_data,
	output logic       stall,
	output logic [7:0] led
);

	ctrl_state_e state;
	mem_req_t    req_buf;
	logic        is_led;
	logic        cache_access;
	logic        lookup;

	function automatic mem_index_t tag_to_index(input tag_t tag);
		tag_t offset_tag;
		offset_tag = tag - tag_t'(`DCACHE_DATA_BASE >> `DCACHE_OFFSET_BITS);
		return mem_index_t'(offset_tag);
	endfunction

	assign lookup = (state == ST_LOOKUP);

	// The live request is served in lookup, the buffered one while a miss is in flight
	assign cur_req = lookup ? req : req_buf;

	assign is_led       = (cur_req.addr == `DCACHE_LED_ADDR);
	assign cache_access = (cur_req.read || cur_req.write) && !is_led;

	assign way_touch = (lookup && cache_access && hit) || (state == ST_FILL);
	assign way_write = (lookup && cache_access && hit && cur_req.write) || (state == ST_FILL);

	// Victim write-back and fill read both happen in ST_MEMORY
	assign mem_we    = (state == ST_MEMORY) && sel_state.valid;
	assign mem_widx  = tag_to_index(sel_state.tag);
	assign mem_wline = sel_data;
	assign mem_ridx  = tag_to_index(cur_req.addr[`DCACHE_ADDR_BITS-1:`DCACHE_OFFSET_BITS]);

	assign stall = !lookup;

	always_ff @(posedge clk) begin
		if (lookup) begin
			req_buf <= req;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state     <= ST_LOOKUP;
			read_data <= '0;
			led       <= '0;
		end else begin
			unique case (state)
				ST_LOOKUP: begin
					if (cache_access) begin
						if (hit) begin
							read_data <= load_word;
						end else begin
							state <= ST_MEMORY;
						end
					end
					if (cur_req.write && is_led) begin
						led <= cur_req.wdata[7:0];
					end
				end
				ST_MEMORY: begin
					state <= ST_FILL;
				end
				ST_FILL: begin
					read_data <= load_word;
					state     <= ST_LOOKUP;
				end
				default: begin
					state <= ST_LOOKUP;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

/* dcache_pkg.sv */
// Shared types of the data cache; widths follow dcache_config.svh and must stay consistent with it
`default_nettype none

`include "dcache_config.svh"

package dcache_pkg;

	typedef logic [`DCACHE_ADDR_BITS-1:0] addr_t;
	typedef logic [31:0] word_t;

	// Line address, the byte address with the offset dropped
	typedef logic [`DCACHE_ADDR_BITS-`DCACHE_OFFSET_BITS-1:0] tag_t;

	typedef logic [`DCACHE_LINE_BYTES*8-1:0] line_data_t;

	// Age 0 marks the oldest way, the highest value the newest
	typedef logic [`DCACHE_AGE_BITS-1:0] age_t;

	typedef logic [$clog2(`DCACHE_MEM_LINES)-1:0] mem_index_t;

	typedef enum logic [1:0] {
		SIZE_BYTE,
		SIZE_HALF,
		SIZE_WORD
	} access_size_e;

	typedef enum logic [1:0] {
		ST_LOOKUP,
		ST_MEMORY,
		ST_FILL
	} ctrl_state_e;

	// One request on the processor memory port
	typedef struct packed {
		logic         read;
		logic         write;
		addr_t        addr;
		word_t        wdata;
		access_size_e size;
		logic         sign_ext;
	} mem_req_t;

	typedef struct packed {
		logic valid;
		tag_t tag;
		age_t age;
	} way_state_t;

endpackage

`default_nettype wire

/* dcache_tb.sv */
// Directed testbench for dcache_top; backing memory is never preloaded, so every line is stored before it is loaded
`timescale 1ns/1ps
`default_nettype none

`include "dcache_config.svh"

module dcache_tb
	import dcache_pkg::*;
();

	// One row of the stimulus table with the responses it should produce
	typedef struct packed {
		logic         write;
		addr_t        addr;
		access_size_e size;
		logic         sign_ext;
		word_t        wdata;
		word_t        exp_data;
		logic         exp_miss;
		logic [7:0]   exp_led;
	} entry_t;

	logic       clk;
	logic       arst_n;
	mem_req_t   req;
	word_t      read_data;
	logic       stall;
	logic [7:0] led;

	entry_t entries [$];
	int     errors;
	int     passed;
	int     failed;
	logic   timed_out;

	dcache_top dut0 (.clk, .arst_n, .req, .read_data, .stall, .led);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	task automatic check_word(input string name, input word_t got, input word_t exp);
		if (got !== exp) begin
			errors++;
			$display("[ERROR] t=%0t %s: expected %h, got %h", $time, name, exp, got);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			errors++;
			$display("[ERROR] t=%0t %s: expected %b, got %b", $time, name, exp, got);
		end
	endtask

	task automatic check_led(input string name, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp) begin
			errors++;
			$display("[ERROR] t=%0t %s: expected %h, got %h", $time, name, exp, got);
		end
	endtask

	task automatic add_entry(input logic write, input addr_t addr, input access_size_e size,
			input logic sign_ext, input word_t wdata, input word_t exp_data,
			input logic exp_miss, input logic [7:0] exp_led);
		entries.push_back('{write, addr, size, sign_ext, wdata, exp_data, exp_miss, exp_led});
	endtask

	// Called 2 ns after a rising edge and returns at the same point of a later cycle
	task automatic run_entry(input int idx);
		entry_t e;
		int     cycles;
		int     errors_before;
		e             = entries[idx];
		errors_before = errors;
		cycles        = 0;
		req           = '{!e.write, e.write, e.addr, e.wdata, e.size, e.sign_ext};
		@(posedge clk);
		#1;
		while (stall && cycles < 20) begin
			cycles++;
			@(posedge clk);
			#1;
		end
		if (stall) begin
			timed_out = 1'b1;
			$display("Timeout: stall still high after 20 cycles at entry %0d", idx);
		end else begin
			check_bit("miss", cycles != 0, e.exp_miss);
			check_word("stall_cycles", word_t'(cycles), e.exp_miss ? 32'd2 : 32'd0);
			check_word("read_data", read_data, e.exp_data);
			check_led("led", led, e.exp_led);
		end
		if (errors == errors_before && !timed_out) begin
			passed++;
		end else begin
			failed++;
		end
		$display("entry %0d addr %h stall %0d: %s", idx, e.addr, cycles,
			(errors == errors_before && !timed_out) ? "ok" : "wrong");
		#1;
	endtask

	initial begin
		errors    = 0;
		passed    = 0;
		failed    = 0;
		timed_out = 1'b0;
		req       = '0;
		arst_n    = 1'b0;

		// Columns are write, addr, size, sign_ext, wdata, expected read_data, miss, led
		add_entry(1'b1, 14'h1000, SIZE_WORD, 1'b0, 32'h1122_3344, 32'h1122_3344, 1'b1, 8'h00);
		add_entry(1'b0, 14'h1000, SIZE_WORD, 1'b0, 32'h0, 32'h1122_3344, 1'b0, 8'h00);
		add_entry(1'b1, 14'h1004, SIZE_WORD, 1'b0, 32'h8899_aabb, 32'h8899_aabb, 1'b0, 8'h00);
		add_entry(1'b1, 14'h1005, SIZE_BYTE, 1'b0, 32'hdead_bef0, 32'h0000_00f0, 1'b0, 8'h00);
		add_entry(1'b1, 14'h1006, SIZE_HALF, 1'b0, 32'hcafe_7e01, 32'h0000_7e01, 1'b0, 8'h00);
		add_entry(1'b0, 14'h1004, SIZE_BYTE, 1'b0, 32'h0, 32'h0000_00bb, 1'b0, 8'h00);
		add_entry(1'b0, 14'h1005, SIZE_BYTE, 1'b1, 32'h0, 32'hffff_fff0, 1'b0, 8'h00);
		add_entry(1'b0, 14'h1006, SIZE_BYTE, 1'b1, 32'h0, 32'h0000_0001, 1'b0, 8'h00);
		add_entry(1'b0, 14'h1007, SIZE_BYTE, 1'b0, 32'h0, 32'h0000_007e, 1'b0, 8'h00);
		add_entry(1'b0, 14'h1004, SIZE_HALF, 1'b1, 32'h0, 32'hffff_f0bb, 1'b0, 8'h00);
		add_entry(1'b0, 14'h1004, SIZE_HALF, 1'b0, 32'h0, 32'h0000_f0bb, 1'b0, 8'h00);
		add_entry(1'b0, 14'h1006, SIZE_HALF, 1'b0, 32'h0, 32'h0000_7e01, 1'b0, 8'h00);
		add_entry(1'b0, 14'h1000, SIZE_WORD, 1'b0, 32'h0, 32'h1122_3344, 1'b0, 8'h00);
		// Five lines through four ways, so A is evicted and must come back from memory
		add_entry(1'b1, 14'h1100, SIZE_WORD, 1'b0, 32'ha0a0_0001, 32'ha0a0_0001, 1'b1, 8'h00);
		add_entry(1'b1, 14'h1108, SIZE_WORD, 1'b0, 32'hb0b0_0002, 32'hb0b0_0002, 1'b1, 8'h00);
		add_entry(1'b1, 14'h1110, SIZE_WORD, 1'b0, 32'hc0c0_0003, 32'hc0c0_0003, 1'b1, 8'h00);
		add_entry(1'b1, 14'h1118, SIZE_WORD, 1'b0, 32'hd0d0_0004, 32'hd0d0_0004, 1'b1, 8'h00);
		add_entry(1'b1, 14'h1120, SIZE_WORD, 1'b0, 32'he0e0_0005, 32'he0e0_0005, 1'b1, 8'h00);
		add_entry(1'b0, 14'h1100, SIZE_WORD, 1'b0, 32'h0, 32'ha0a0_0001, 1'b1, 8'h00);
		// Re-reading A (0x1200) makes B (0x1208) the oldest before E arrives
		add_entry(1'b1, 14'h1200, SIZE_WORD, 1'b0, 32'h5151_0006, 32'h5151_0006, 1'b1, 8'h00);
		add_entry(1'b1, 14'h1208, SIZE_WORD, 1'b0, 32'h6262_0007, 32'h6262_0007, 1'b1, 8'h00);
		add_entry(1'b1, 14'h1210, SIZE_WORD, 1'b0, 32'h7373_0008, 32'h7373_0008, 1'b1, 8'h00);
		add_entry(1'b1, 14'h1218, SIZE_WORD, 1'b0, 32'h8484_0009, 32'h8484_0009, 1'b1, 8'h00);
		add_entry(1'b0, 14'h1200, SIZE_WORD, 1'b0, 32'h0, 32'h5151_0006, 1'b0, 8'h00);
		add_entry(1'b1, 14'h1220, SIZE_WORD, 1'b0, 32'h9595_000a, 32'h9595_000a, 1'b1, 8'h00);
		add_entry(1'b0, 14'h1200, SIZE_WORD, 1'b0, 32'h0, 32'h5151_0006, 1'b0, 8'h00);
		add_entry(1'b0, 14'h1208, SIZE_WORD, 1'b0, 32'h0, 32'h6262_0007, 1'b1, 8'h00);
		// The LED store leaves read_data at the last load value
		add_entry(1'b1, 14'h2000, SIZE_WORD, 1'b0, 32'h1234_56a5, 32'h6262_0007, 1'b0, 8'ha5);
		add_entry(1'b0, 14'h1200, SIZE_WORD, 1'b0, 32'h0, 32'h5151_0006, 1'b0, 8'ha5);

		for (int i = 0; i < 3; i++) begin
			@(posedge clk);
		end
		#2;
		arst_n = 1'b1;
		check_bit("stall", stall, 1'b0);
		check_led("led", led, 8'h00);
		check_word("read_data", read_data, 32'h0);
		$display("reset values: %s", (errors == 0) ? "ok" : "wrong");

		for (int i = 0; i < entries.size() && !timed_out; i++) begin
			run_entry(i);
		end
		req = '0;

		$display("entries passed %0d, failed %0d, errors %0d", passed, failed, errors);
		if (errors == 0 && !timed_out) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* dcache_top.sv */
// Data cache top level; the requester must hold off new requests while stall is high
`timescale 1ns/1ps
`default_nettype none

`include "dcache_config.svh"

module dcache_top
	import dcache_pkg::*;
(
	input  wire        clk,
	input  wire        arst_n,
	input  mem_req_t   req,
	output word_t      read_data,
	output logic       stall,
	output logic [7:0] led
);

	mem_req_t                 cur_req;
	logic                     hit;
	logic [`DCACHE_LINES-1:0] select;
	way_state_t               sel_state;
	line_data_t               sel_data;
	way_state_t               way_states [`DCACHE_LINES];
	line_data_t               way_data [`DCACHE_LINES];
	line_data_t               wline;
	line_data_t               fill_line;
	word_t                    load_word;
	logic                     way_write;
	logic                     way_touch;
	logic                     mem_we;
	mem_index_t               mem_widx;
	line_data_t               mem_wline;
	mem_index_t               mem_ridx;

	dcache_ctrl u_ctrl (
		.clk, .arst_n, .req, .cur_req, .hit, .sel_state, .sel_data, .load_word,
		.way_write, .way_touch, .mem_we, .mem_widx, .mem_wline, .mem_ridx,
		.read_data, .stall, .led
	);

	for (genvar i = 0; i < `DCACHE_LINES; i++) begin : g_way
		cache_line #(.init_age(i)) u_way (
			.clk, .arst_n, .cur_addr(cur_req.addr), .select(select[i]),
			.acc_age(sel_state.age), .touch(way_touch), .write(way_write), .wline,
			.state(way_states[i]), .data(way_data[i])
		);
	end

	line_select u_select (
		.cur_addr(cur_req.addr), .way_states, .way_data, .hit, .select, .sel_state, .sel_data
	);

	// The aligner output only matters in ST_FILL while stalled, so stall marks the fill
	load_store_align u_align (
		.cur_req, .filling(stall), .sel_data, .fill_data(fill_line), .wline, .load_word
	);

	backing_memory u_mem (
		.clk, .we(mem_we), .widx(mem_widx), .wline(mem_wline), .ridx(mem_ridx), .rline(fill_line)
	);

endmodule

`default_nettype wire

/* line_select.sv */
// Way selection for a fully associative lookup; assumes the way ages are a permutation so one way has age 0
`timescale 1ns/1ps
`default_nettype none

`include "dcache_config.svh"

module line_select
	import dcache_pkg::*;
(
	input  addr_t                   cur_addr,
	input  way_state_t              way_states [`DCACHE_LINES],
	input  line_data_t              way_data [`DCACHE_LINES],
	output logic                    hit,
	output logic [`DCACHE_LINES-1:0] select,
	output way_state_t              sel_state,
	output line_data_t              sel_data
);

	logic [`DCACHE_LINES-1:0] match;
	logic [`DCACHE_LINES-1:0] oldest;
	tag_t                     addr_tag;

	assign addr_tag = cur_addr[`DCACHE_ADDR_BITS-1:`DCACHE_OFFSET_BITS];

	always_comb begin
		for (int i = 0; i < `DCACHE_LINES; i++) begin
			match[i]  = way_states[i].valid && (way_states[i].tag == addr_tag);
			oldest[i] = (way_states[i].age == '0);
		end
	end

	assign hit = |match;

	// On a miss the oldest way is the victim
	assign select = hit ? match : oldest;

	// The AND-OR multiplexer works because select is one-hot
	always_comb begin
		sel_state = '0;
		sel_data  = '0;
		for (int i = 0; i < `DCACHE_LINES; i++) begin
			sel_state = way_state_t'(sel_state | ({$bits(way_state_t){select[i]}} & way_states[i]));
			sel_data  = sel_data | ({$bits(line_data_t){select[i]}} & way_data[i]);
		end
	end

endmodule

`default_nettype wire

/* load_store_align.sv */
// Byte lane alignment for loads and stores; halfword and word accesses are assumed to be naturally aligned
`timescale 1ns/1ps
`default_nettype none

`include "dcache_config.svh"

module load_store_align
	import dcache_pkg::*;
(
	input  mem_req_t   cur_req,
	input  wire        filling,
	input  line_data_t sel_data,
	input  line_data_t fill_data,
	output line_data_t wline,
	output word_t      load_word
);

	word_t [`DCACHE_LINE_WORDS-1:0] base_words;
	word_t [`DCACHE_LINE_WORDS-1:0] merged_words;
	logic [`DCACHE_OFFSET_BITS-3:0] word_idx;
	logic [1:0]                     byte_off;
	word_t                          base_word;
	word_t                          merged_word;
	logic [7:0]                     load_byte;
	logic [15:0]                    load_half;

	assign word_idx = cur_req.addr[`DCACHE_OFFSET_BITS-1:2];
	assign byte_off = cur_req.addr[1:0];

	// During a fill the line arrives from memory instead of the way
	assign base_words = filling ? fill_data : sel_data;
	assign base_word  = base_words[word_idx];

	// Store merge into the addressed word
	always_comb begin
		merged_word = base_word;
		unique case (cur_req.size)
			SIZE_BYTE: merged_word[byte_off*8 +: 8] = cur_req.wdata[7:0];
			SIZE_HALF: merged_word[byte_off[1]*16 +: 16] = cur_req.wdata[15:0];
			default:   merged_word = cur_req.wdata;
		endcase
	end

	always_comb begin
		merged_words = base_words;
		if (cur_req.write) begin
			merged_words[word_idx] = merged_word;
		end
	end

	assign wline = merged_words;

	// Loads read the merged line so a store reports what it left behind
	assign load_byte = merged_words[word_idx][byte_off*8 +: 8];
	assign load_half = merged_words[word_idx][byte_off[1]*16 +: 16];

	always_comb begin
		unique case (cur_req.size)
			SIZE_BYTE: begin
				load_word = {{24{cur_req.sign_ext & load_byte[7]}}, load_byte};
			end
			SIZE_HALF: begin
				load_word = {{16{cur_req.sign_ext & load_half[15]}}, load_half};
			end
			default: begin
				load_word = merged_words[word_idx];
			end
		endcase
	end

endmodule

`default_nettype wire
